// File: design/i2c_core.sv
/*
  I2C host controller top level with APB register port,
  format and receive queues, interrupts and host engine
*/
`timescale 1ns/1ps

module i2c_core (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  i2c_pkg::apb_addr_t paddr_i,
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  i2c_pkg::apb_data_t pwdata_i,
  output i2c_pkg::apb_data_t prdata_o,
  output logic               pready_o,
  output logic               pslverr_o,
  input  logic               scl_i,
  input  logic               sda_i,
  output logic               scl_o,
  output logic               sda_o,
  output i2c_pkg::intr_vec_t intr_o
);
  import i2c_pkg::*;

  logic       fmt_wvalid;
  logic       fmt_wready;
  fmt_entry_t fmt_wdata;
  logic       fmt_rvalid;
  logic       fmt_rready;
  fmt_entry_t fmt_rdata;
  fifo_lvl_t  fmt_lvl;
  logic       fmt_clr;
  logic       rx_wvalid;
  logic       rx_wready;
  i2c_byte_t  rx_wdata;
  logic       rx_rvalid;
  logic       rx_rready;
  i2c_byte_t  rx_rdata;
  fifo_lvl_t  rx_lvl;
  logic       rx_clr;
  logic       host_enable;
  logic       host_idle;
  phase_cnt_t thigh;
  phase_cnt_t tlow;
  logic       scl_fsm;
  logic       sda_fsm;
  intr_vec_t  intr_state;
  intr_vec_t  intr_enable;
  intr_vec_t  intr_test;
  intr_vec_t  intr_clr;
  logic [2:0] rx_ilvl;
  logic [1:0] fmt_ilvl;
  logic       event_nak;
  logic       event_cmplt;

  i2c_regs u_regs (
    .clk_i,
    .rst_ni,
    .paddr_i,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .pwdata_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .fmt_wvalid_o (fmt_wvalid),
    .fmt_wready_i (fmt_wready),
    .fmt_wdata_o  (fmt_wdata),
    .rx_rready_o  (rx_rready),
    .rx_rvalid_i  (rx_rvalid),
    .rx_rdata_i   (rx_rdata),
    .fmt_lvl_i    (fmt_lvl),
    .rx_lvl_i     (rx_lvl),
    .fmt_clr_o    (fmt_clr),
    .rx_clr_o     (rx_clr),
    .host_enable_o(host_enable),
    .host_idle_i  (host_idle),
    .thigh_o      (thigh),
    .tlow_o       (tlow),
    .scl_fsm_i    (scl_fsm),
    .sda_fsm_i    (sda_fsm),
    .scl_i,
    .sda_i,
    .scl_o,
    .sda_o,
    .intr_state_i (intr_state),
    .intr_enable_o(intr_enable),
    .intr_test_o  (intr_test),
    .intr_clr_o   (intr_clr),
    .rx_ilvl_o    (rx_ilvl),
    .fmt_ilvl_o   (fmt_ilvl)
  );

  i2c_fifo #(
    .Width($bits(fmt_entry_t)),
    .Depth(FifoDepth)
  ) u_fmt_fifo (
    .clk_i,
    .rst_ni,
    .clr_i   (fmt_clr),
    .wvalid_i(fmt_wvalid),
    .wready_o(fmt_wready),
    .wdata_i (fmt_wdata),
    .rvalid_o(fmt_rvalid),
    .rready_i(fmt_rready),
    .rdata_o (fmt_rdata),
    .depth_o (fmt_lvl)
  );

  i2c_fifo #(
    .Width($bits(i2c_byte_t)),
    .Depth(FifoDepth)
  ) u_rx_fifo (
    .clk_i,
    .rst_ni,
    .clr_i   (rx_clr),
    .wvalid_i(rx_wvalid),
    .wready_o(rx_wready),
    .wdata_i (rx_wdata),
    .rvalid_o(rx_rvalid),
    .rready_i(rx_rready),
    .rdata_o (rx_rdata),
    .depth_o (rx_lvl)
  );

  i2c_intr u_intr (
    .clk_i,
    .rst_ni,
    .fmt_lvl_i    (fmt_lvl),
    .rx_lvl_i     (rx_lvl),
    .fmt_ilvl_i   (fmt_ilvl),
    .rx_ilvl_i    (rx_ilvl),
    .fmt_wvalid_i (fmt_wvalid),
    .fmt_wready_i (fmt_wready),
    .rx_wvalid_i  (rx_wvalid),
    .rx_wready_i  (rx_wready),
    .event_nak_i  (event_nak),
    .event_cmplt_i(event_cmplt),
    .intr_enable_i(intr_enable),
    .intr_test_i  (intr_test),
    .intr_clr_i   (intr_clr),
    .intr_state_o (intr_state),
    .intr_o
  );

  i2c_host_fsm u_host (
    .clk_i,
    .rst_ni,
    .scl_i,
    .sda_i,
    .scl_o        (scl_fsm),
    .sda_o        (sda_fsm),
    .host_enable_i(host_enable),
    .thigh_i      (thigh),
    .tlow_i       (tlow),
    .fmt_rvalid_i (fmt_rvalid),
    .fmt_rready_o (fmt_rready),
    .fmt_rdata_i  (fmt_rdata),
    .rx_wvalid_o  (rx_wvalid),
    .rx_wdata_o   (rx_wdata),
    .host_idle_o  (host_idle),
    .event_nak_o  (event_nak),
    .event_cmplt_o(event_cmplt)
  );

endmodule

// File: design/i2c_fifo.sv
/*
  Synchronous queue with valid/ready on both sides, a clear input
  and a fill level output
*/
`timescale 1ns/1ps

module i2c_fifo #(
  parameter int Width = 8,
  parameter int Depth = i2c_pkg::FifoDepth
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clr_i,
  input  logic               wvalid_i,
  output logic               wready_o,
  input  logic [Width-1:0]   wdata_i,
  output logic               rvalid_o,
  input  logic               rready_i,
  output logic [Width-1:0]   rdata_o,
  output i2c_pkg::fifo_lvl_t depth_o
);
  import i2c_pkg::*;

  localparam int PtrW = $clog2(Depth);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q;
  logic [PtrW-1:0]  rptr_q;
  fifo_lvl_t        cnt_q;
  logic             push;
  logic             pop;

  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign wready_o = (cnt_q != fifo_lvl_t'(Depth));
  assign rvalid_o = (cnt_q != '0);
  assign push     = wvalid_i & wready_o;
  assign pop      = rready_i & rvalid_o;
  assign rdata_o  = mem_q[rptr_q];
  assign depth_o  = cnt_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni || clr_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) wptr_q <= ptr_inc(wptr_q);
      if (pop) rptr_q <= ptr_inc(rptr_q);
      cnt_q <= cnt_q + fifo_lvl_t'(push) - fifo_lvl_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= wdata_i;
  end

endmodule

// File: design/i2c_host_fsm.sv
/*
  I2C host engine: synchronizes the bus lines, times the SCL phases
  and turns format entries into START, bytes, ACK bits and STOP
*/
`timescale 1ns/1ps

module i2c_host_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                scl_i,
  input  logic                sda_i,
  output logic                scl_o,
  output logic                sda_o,
  input  logic                host_enable_i,
  input  i2c_pkg::phase_cnt_t thigh_i,
  input  i2c_pkg::phase_cnt_t tlow_i,
  input  logic                fmt_rvalid_i,
  output logic                fmt_rready_o,
  input  i2c_pkg::fmt_entry_t fmt_rdata_i,
  output logic                rx_wvalid_o,
  output i2c_pkg::i2c_byte_t  rx_wdata_o,
  output logic                host_idle_o,
  output logic                event_nak_o,
  output logic                event_cmplt_o
);
  import i2c_pkg::*;

  logic [1:0]  scl_sync_q;
  logic [1:0]  sda_sync_q;
  logic        scl_sync;
  logic        sda_sync;
  host_state_e state_q;
  logic        phase_hi_q;
  logic        hold_q;
  phase_cnt_t  cnt_q;
  phase_cnt_t  lim;
  phase_cnt_t  half;
  logic        phase_end;
  logic        bit_end;
  logic [2:0]  bit_idx_q;
  logic [8:0]  rd_cnt_q;
  fmt_entry_t  entry_q;
  i2c_byte_t   sreg_q;
  logic        ack_done;
  logic        want_entry;
  logic        load;
  logic        ack_bit;
  logic        sda_next;
  logic        scl_q;
  logic        sda_q;

  assign scl_sync = scl_sync_q[1];
  assign sda_sync = sda_sync_q[1];

  // Each bit is a low phase of tlow cycles then a high phase of thigh
  assign lim       = phase_hi_q ? thigh_i : tlow_i;
  assign half      = thigh_i >> 1;
  assign phase_end = (lim == '0) || (cnt_q >= lim - 1'b1);
  assign bit_end   = phase_end & phase_hi_q;
  assign ack_bit   = (rd_cnt_q != 9'd1) | entry_q.rcont;

  assign ack_done = bit_end && ((state_q == StAckIn) ||
                                (state_q == StAckOut && rd_cnt_q == 9'd1));
  // A new entry is taken from a free bus, or with SCL held low mid-transaction
  assign want_entry = (state_q == StIdle && scl_sync && sda_sync) || hold_q ||
                      (ack_done && !entry_q.stop);
  assign load         = want_entry & host_enable_i & fmt_rvalid_i;
  assign fmt_rready_o = load;

  assign rx_wvalid_o   = bit_end && (state_q == StReadBit) && (bit_idx_q == '0);
  assign rx_wdata_o    = {sreg_q[6:0], sda_sync};
  assign event_nak_o   = bit_end && (state_q == StAckIn) && sda_sync && !entry_q.nakok;
  assign event_cmplt_o = bit_end && (state_q == StStop);
  assign host_idle_o   = (state_q == StIdle);

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q    <= StIdle;
      phase_hi_q <= 1'b0;
      hold_q     <= 1'b0;
      cnt_q      <= '0;
      bit_idx_q  <= '0;
      rd_cnt_q   <= '0;
    end else if (load) begin
      hold_q    <= 1'b0;
      cnt_q     <= '0;
      bit_idx_q <= 3'd7;
      rd_cnt_q  <= {fmt_rdata_i.fbyte == '0, fmt_rdata_i.fbyte};
      // SCL is already high when starting from idle
      phase_hi_q <= (state_q == StIdle) && fmt_rdata_i.start;
      if (fmt_rdata_i.start) state_q <= StStart;
      else if (fmt_rdata_i.read) state_q <= StReadBit;
      else state_q <= StWriteBit;
    end else if (state_q != StIdle && !hold_q) begin
      if (!phase_end) begin
        cnt_q <= cnt_q + 1'b1;
      end else begin
        cnt_q      <= '0;
        phase_hi_q <= ~phase_hi_q;
        if (phase_hi_q) begin
          case (state_q)
            StStart: state_q <= entry_q.read ? StReadBit : StWriteBit;
            StWriteBit, StReadBit: begin
              // Wraps back to 7 for the next byte
              bit_idx_q <= bit_idx_q - 1'b1;
              if (bit_idx_q == '0) begin
                state_q <= (state_q == StWriteBit) ? StAckIn : StAckOut;
              end
            end
            StAckIn, StAckOut: begin
              rd_cnt_q <= rd_cnt_q - 1'b1;
              if (state_q == StAckOut && rd_cnt_q != 9'd1) state_q <= StReadBit;
              else if (entry_q.stop) state_q <= StStop;
              else hold_q <= 1'b1;
            end
            StStop: state_q <= StIdle;
            default: state_q <= StIdle;
          endcase
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      entry_q <= fmt_rdata_i;
      sreg_q  <= fmt_rdata_i.fbyte;
    end else if (bit_end && (state_q == StWriteBit || state_q == StReadBit)) begin
      sreg_q <= {sreg_q[6:0], sda_sync};
    end
  end

  // START and STOP move SDA halfway through the high phase
  always_comb begin
    case (state_q)
      StStart:    sda_next = !phase_hi_q || (cnt_q < half);
      StWriteBit: sda_next = sreg_q[7];
      StAckOut:   sda_next = ~ack_bit;
      StStop:     sda_next = phase_hi_q && (cnt_q >= half);
      default:    sda_next = 1'b1;
    endcase
  end

  // SDA waits one cycle after SCL falls, so tlow must be at least 2
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
      scl_q      <= 1'b1;
      sda_q      <= 1'b1;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
      scl_q      <= (state_q == StIdle) || phase_hi_q;
      sda_q      <= (!phase_hi_q && cnt_q == '0) ? sda_q : sda_next;
    end
  end

  assign scl_o = scl_q;
  assign sda_o = sda_q;

endmodule

// File: design/i2c_intr.sv
/*
  Interrupt logic: watermark edges, queue overflows and host events
  feed sticky state bits that are masked by the enable register
*/
`timescale 1ns/1ps

module i2c_intr (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  i2c_pkg::fifo_lvl_t fmt_lvl_i,
  input  i2c_pkg::fifo_lvl_t rx_lvl_i,
  input  logic [1:0]         fmt_ilvl_i,
  input  logic [2:0]         rx_ilvl_i,
  input  logic               fmt_wvalid_i,
  input  logic               fmt_wready_i,
  input  logic               rx_wvalid_i,
  input  logic               rx_wready_i,
  input  logic               event_nak_i,
  input  logic               event_cmplt_i,
  input  i2c_pkg::intr_vec_t intr_enable_i,
  input  i2c_pkg::intr_vec_t intr_test_i,
  input  i2c_pkg::intr_vec_t intr_clr_i,
  output i2c_pkg::intr_vec_t intr_state_o,
  output i2c_pkg::intr_vec_t intr_o
);
  import i2c_pkg::*;

  logic      fmt_wm_d;
  logic      fmt_wm_q;
  logic      rx_wm_d;
  logic      rx_wm_q;
  intr_vec_t events;
  intr_vec_t state_q;

  assign fmt_wm_d = (fmt_lvl_i <= FmtWmLevels[fmt_ilvl_i]);
  // Codes above 4 select no threshold
  assign rx_wm_d  = (rx_ilvl_i <= 3'd4) && (rx_lvl_i >= RxWmLevels[rx_ilvl_i]);

  always_comb begin
    events             = '0;
    events[IntrFmtWm]  = fmt_wm_d & ~fmt_wm_q;
    events[IntrRxWm]   = rx_wm_d & ~rx_wm_q;
    events[IntrFmtOvf] = fmt_wvalid_i & ~fmt_wready_i;
    events[IntrRxOvf]  = rx_wvalid_i & ~rx_wready_i;
    events[IntrNak]    = event_nak_i;
    events[IntrCmplt]  = event_cmplt_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      fmt_wm_q <= 1'b1;
      rx_wm_q  <= 1'b0;
      state_q  <= '0;
    end else begin
      fmt_wm_q <= fmt_wm_d;
      rx_wm_q  <= rx_wm_d;
      // A new event wins over a clear in the same cycle
      state_q  <= (state_q & ~intr_clr_i) | events | intr_test_i;
    end
  end

  assign intr_state_o = state_q;
  assign intr_o       = state_q & intr_enable_i;

endmodule

// File: design/i2c_pkg.sv
/*
  Shared definitions for the I2C host controller: bus and register
  types, format entry layout, register map and watermark thresholds
*/
package i2c_pkg;

  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [7:0]  i2c_byte_t;
  typedef logic [5:0]  fifo_lvl_t;
  typedef logic [15:0] phase_cnt_t;
  typedef logic [5:0]  intr_vec_t;

  // Bit order matches the FDATA register
  typedef struct packed {
    logic      nakok;
    logic      rcont;
    logic      read;
    logic      stop;
    logic      start;
    i2c_byte_t fbyte;
  } fmt_entry_t;

  localparam int FifoDepth = 32;

  localparam int IntrFmtWm  = 0;
  localparam int IntrRxWm   = 1;
  localparam int IntrFmtOvf = 2;
  localparam int IntrRxOvf  = 3;
  localparam int IntrNak    = 4;
  localparam int IntrCmplt  = 5;

  localparam apb_addr_t RegCtrl       = 8'h00;
  localparam apb_addr_t RegStatus     = 8'h04;
  localparam apb_addr_t RegRdata      = 8'h08;
  localparam apb_addr_t RegFdata      = 8'h0C;
  localparam apb_addr_t RegFifoCtrl   = 8'h10;
  localparam apb_addr_t RegFifoStatus = 8'h14;
  localparam apb_addr_t RegOvrd       = 8'h18;
  localparam apb_addr_t RegTiming0    = 8'h1C;
  localparam apb_addr_t RegIntrState  = 8'h20;
  localparam apb_addr_t RegIntrEnable = 8'h24;
  localparam apb_addr_t RegIntrTest   = 8'h28;

  // Format watermark holds at or below, receive watermark at or above
  localparam fifo_lvl_t FmtWmLevels [4] = '{6'd1, 6'd4, 6'd8, 6'd16};
  localparam fifo_lvl_t RxWmLevels [5]  = '{6'd1, 6'd4, 6'd8, 6'd16, 6'd30};

  typedef enum logic [2:0] {
    StIdle,
    StStart,
    StWriteBit,
    StAckIn,
    StReadBit,
    StAckOut,
    StStop
  } host_state_e;

endpackage

// File: design/i2c_regs.sv
/*
  APB register file: configuration, queue access and control,
  interrupt registers and the SCL/SDA override
*/
`timescale 1ns/1ps

module i2c_regs (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  i2c_pkg::apb_addr_t  paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  i2c_pkg::apb_data_t  pwdata_i,
  output i2c_pkg::apb_data_t  prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  output logic                fmt_wvalid_o,
  input  logic                fmt_wready_i,
  output i2c_pkg::fmt_entry_t fmt_wdata_o,
  output logic                rx_rready_o,
  input  logic                rx_rvalid_i,
  input  i2c_pkg::i2c_byte_t  rx_rdata_i,
  input  i2c_pkg::fifo_lvl_t  fmt_lvl_i,
  input  i2c_pkg::fifo_lvl_t  rx_lvl_i,
  output logic                fmt_clr_o,
  output logic                rx_clr_o,
  output logic                host_enable_o,
  input  logic                host_idle_i,
  output i2c_pkg::phase_cnt_t thigh_o,
  output i2c_pkg::phase_cnt_t tlow_o,
  input  logic                scl_fsm_i,
  input  logic                sda_fsm_i,
  input  logic                scl_i,
  input  logic                sda_i,
  output logic                scl_o,
  output logic                sda_o,
  input  i2c_pkg::intr_vec_t  intr_state_i,
  output i2c_pkg::intr_vec_t  intr_enable_o,
  output i2c_pkg::intr_vec_t  intr_test_o,
  output i2c_pkg::intr_vec_t  intr_clr_o,
  output logic [2:0]          rx_ilvl_o,
  output logic [1:0]          fmt_ilvl_o
);
  import i2c_pkg::*;

  logic      wr_en;
  logic      rd_en;
  logic      addr_ok;
  logic      ovrd_en_q;
  logic      scl_val_q;
  logic      sda_val_q;
  apb_data_t rdata;

  // Access phase with pready tied high
  assign wr_en    = psel_i & penable_i & pwrite_i;
  assign rd_en    = psel_i & penable_i & ~pwrite_i;
  assign pready_o = 1'b1;

  assign fmt_wvalid_o = wr_en && (paddr_i == RegFdata);
  assign fmt_wdata_o  = fmt_entry_t'(pwdata_i[12:0]);
  assign rx_rready_o  = rd_en && (paddr_i == RegRdata);
  assign rx_clr_o     = wr_en && (paddr_i == RegFifoCtrl) && pwdata_i[0];
  assign fmt_clr_o    = wr_en && (paddr_i == RegFifoCtrl) && pwdata_i[1];
  assign intr_clr_o   = (wr_en && (paddr_i == RegIntrState)) ? pwdata_i[5:0] : '0;
  assign intr_test_o  = (wr_en && (paddr_i == RegIntrTest)) ? pwdata_i[5:0] : '0;

  assign scl_o = ovrd_en_q ? scl_val_q : scl_fsm_i;
  assign sda_o = ovrd_en_q ? sda_val_q : sda_fsm_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      host_enable_o <= 1'b0;
      rx_ilvl_o     <= '0;
      fmt_ilvl_o    <= '0;
      ovrd_en_q     <= 1'b0;
      scl_val_q     <= 1'b0;
      sda_val_q     <= 1'b0;
      thigh_o       <= '0;
      tlow_o        <= '0;
      intr_enable_o <= '0;
    end else if (wr_en) begin
      case (paddr_i)
        RegCtrl: host_enable_o <= pwdata_i[0];
        RegFifoCtrl: begin
          rx_ilvl_o  <= pwdata_i[4:2];
          fmt_ilvl_o <= pwdata_i[6:5];
        end
        RegOvrd: begin
          ovrd_en_q <= pwdata_i[0];
          scl_val_q <= pwdata_i[1];
          sda_val_q <= pwdata_i[2];
        end
        RegTiming0: begin
          thigh_o <= pwdata_i[15:0];
          tlow_o  <= pwdata_i[31:16];
        end
        RegIntrEnable: intr_enable_o <= pwdata_i[5:0];
        default: ;
      endcase
    end
  end

  always_comb begin
    rdata   = '0;
    addr_ok = 1'b1;
    case (paddr_i)
      RegCtrl: rdata[0] = host_enable_o;
      // bit 4 is kept free, rxempty sits at bit 5
      RegStatus: begin
        rdata[0] = ~fmt_wready_i;
        rdata[1] = (rx_lvl_i == fifo_lvl_t'(FifoDepth));
        rdata[2] = (fmt_lvl_i == '0);
        rdata[3] = host_idle_i;
        rdata[5] = ~rx_rvalid_i;
      end
      RegRdata: rdata[7:0] = rx_rdata_i;
      RegFdata: ;
      RegFifoCtrl: rdata[6:2] = {fmt_ilvl_o, rx_ilvl_o};
      RegFifoStatus: rdata = {10'b0, rx_lvl_i, 10'b0, fmt_lvl_i};
      // Raw line state reads back in the upper half
      RegOvrd: rdata = {14'b0, sda_i, scl_i, 13'b0, sda_val_q, scl_val_q, ovrd_en_q};
      RegTiming0: rdata = {tlow_o, thigh_o};
      RegIntrState: rdata[5:0] = intr_state_i;
      RegIntrEnable: rdata[5:0] = intr_enable_o;
      RegIntrTest: ;
      default: addr_ok = 1'b0;
    endcase
  end

  assign prdata_o  = rdata;
  assign pslverr_o = psel_i & penable_i & ~addr_ok;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator, result decided from sim.log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_i2c_core -o sim \
  > build.log 2>&1 &&
  ./obj_dir/sim > sim.log 2>&1 ||
  echo "build or simulation did not complete"
grep -q "Verification passed" sim.log 2>/dev/null && echo "PASS" || {
  echo "FAIL"
  exit 1
}

// File: testbench/i2c_target_model.sv
/*
  Behavioral I2C target: answers one 7-bit address, records written
  bytes and returns bytes from a preloaded list on reads
*/
`timescale 1ns/1ps

module i2c_target_model #(
  parameter logic [6:0] Addr = 7'h42
) (
  input  logic clk_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic sda_o
);

  logic [7:0] wr_log [$];
  logic [7:0] rd_q [$];
  logic       scl_p;
  logic       sda_p;
  logic [7:0] sr;
  logic [7:0] tx;
  int         bit_cnt;
  logic       addr_ph;
  logic       active;
  logic       rw;
  logic       mack;

  initial begin
    sda_o   = 1'b1;
    scl_p   = 1'b1;
    sda_p   = 1'b1;
    sr      = '0;
    tx      = 8'hff;
    bit_cnt = 0;
    addr_ph = 1'b0;
    active  = 1'b0;
    rw      = 1'b0;
    mack    = 1'b0;
  end

  // Bus lines are sampled on the system clock, edges found from the previous sample
  always @(posedge clk_i) begin
    if (scl_p && scl_i && sda_p && !sda_i) begin
      // START
      bit_cnt = 0;
      addr_ph = 1'b1;
      active  = 1'b0;
      sda_o  <= 1'b1;
    end else if (scl_p && scl_i && !sda_p && sda_i) begin
      // STOP
      bit_cnt = 0;
      addr_ph = 1'b0;
      active  = 1'b0;
      sda_o  <= 1'b1;
    end else if (!scl_p && scl_i) begin
      if (bit_cnt < 8) sr = {sr[6:0], sda_i};
      else mack = !sda_i;
      bit_cnt++;
    end else if (scl_p && !scl_i) begin
      if (bit_cnt == 8) begin
        if (addr_ph) begin
          active = (sr[7:1] == Addr);
          rw     = sr[0];
          sda_o <= !active;
        end else if (active && !rw) begin
          wr_log.push_back(sr);
          sda_o <= 1'b0;
        end else begin
          sda_o <= 1'b1;
        end
      end else if (bit_cnt == 9) begin
        bit_cnt = 0;
        // Next read byte only after an address ACK or a host ACK
        if (active && rw && (addr_ph || mack) && rd_q.size() > 0) begin
          tx = rd_q.pop_front();
          sda_o <= tx[7];
        end else begin
          sda_o <= 1'b1;
        end
        addr_ph = 1'b0;
      end else if (active && rw && !addr_ph && bit_cnt > 0) begin
        sda_o <= tx[7-bit_cnt];
      end
    end
    scl_p = scl_i;
    sda_p = sda_i;
  end

endmodule

// File: testbench/tb_i2c_core.sv
/*
  Testbench for the I2C host controller with APB driven write, read and
  NAK transactions against a target model, plus queue, interrupt and override checks
*/
`timescale 1ns/1ps

module tb_i2c_core;
  import i2c_pkg::*;

  localparam int ClkPeriod = 40;
  localparam int Thigh     = 4;
  localparam int Tlow      = 4;
  localparam int NumWr     = 6;
  localparam int NumRd     = 6;
  localparam int NumTx     = NumWr + NumRd + 2;
  localparam int PollMax   = 2000;
  localparam int WatchdogNs = (NumTx * 9 * 9 * (Thigh + Tlow) + 5000) * ClkPeriod;
  localparam logic [6:0] TgtAddr = 7'h42;
  localparam int RxThr [5] = '{1, 4, 8, 16, 30};

  logic      clk;
  logic      rst_n;
  apb_addr_t paddr;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      dut_scl;
  logic      dut_sda;
  logic      tgt_sda;
  wire       scl_bus;
  wire       sda_bus;
  intr_vec_t intr;
  int        errors;
  int        checks;

  // Open-drain bus as wired-AND
  assign scl_bus = dut_scl;
  assign sda_bus = dut_sda & tgt_sda;

  i2c_core u_dut (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .paddr_i  (paddr),
    .psel_i   (psel),
    .penable_i(penable),
    .pwrite_i (pwrite),
    .pwdata_i (pwdata),
    .prdata_o (prdata),
    .pready_o (pready),
    .pslverr_o(pslverr),
    .scl_i    (scl_bus),
    .sda_i    (sda_bus),
    .scl_o    (dut_scl),
    .sda_o    (dut_sda),
    .intr_o   (intr)
  );

  i2c_target_model #(.Addr(TgtAddr)) u_tgt (
    .clk_i(clk),
    .scl_i(scl_bus),
    .sda_i(sda_bus),
    .sda_o(tgt_sda)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: the tests did not finish in time");
    $display("Verification failed");
    $finish;
  end

  function automatic apb_data_t fmt_word(input logic start, input logic stop, input logic rd,
                                         input logic rcont, input logic nakok,
                                         input logic [7:0] b);
    return {19'b0, nakok, rcont, rd, stop, start, b};
  endfunction

  // Word aligned offsets from RegCtrl up to RegIntrTest
  function automatic logic addr_mapped(input apb_addr_t a);
    return (a[1:0] == 2'b00) && (a <= RegIntrTest);
  endfunction

  task automatic check_val(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Tasks start and end 1 ns after a rising edge
  task automatic apb_write(input apb_addr_t a, input apb_data_t d);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = a;
    pwdata  = d;
    @(posedge clk);
    #1 penable = 1'b1;
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t a, output apb_data_t d);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = a;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    d = prdata;
    check_val("pready", pready, 1);
    check_val("pslverr", pslverr, !addr_mapped(a));
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_cmplt(output apb_data_t st);
    int n;
    st = '0;
    n  = 0;
    while (!st[IntrCmplt] && n < PollMax) begin
      apb_read(RegIntrState, st);
      n++;
    end
    checks++;
    assert (st[IntrCmplt]) else begin
      errors++;
      $display("Error at %0t: transaction never completed", $time);
    end
  endtask

  task automatic write_txn(input int n);
    logic [7:0] data [$];
    logic [7:0] b;
    apb_data_t  st;
    u_tgt.wr_log.delete();
    apb_write(RegIntrState, 32'h3f);
    apb_write(RegFdata, fmt_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, {TgtAddr, 1'b0}));
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      data.push_back(b);
      apb_write(RegFdata, fmt_word(1'b0, i == n - 1, 1'b0, 1'b0, 1'b0, b));
    end
    wait_cmplt(st);
    check_val("write nak", st[IntrNak], 0);
    check_val("target log size", u_tgt.wr_log.size(), n);
    for (int i = 0; i < n && i < u_tgt.wr_log.size(); i++) begin
      check_val("target byte", u_tgt.wr_log[i], data[i]);
    end
    apb_read(RegFifoStatus, st);
    check_val("fmtlvl after write", st[5:0], 0);
  endtask

  task automatic read_txn(input int n);
    logic [7:0] exp_q [$];
    logic [7:0] b;
    logic [2:0] code;
    logic       exp_wm;
    apb_data_t  st;
    code = 3'($urandom_range(0, 7));
    apb_write(RegFifoCtrl, {25'b0, 2'b00, code, 2'b00});
    apb_write(RegIntrState, 32'h3f);
    for (int i = 0; i < n; i++) begin
      b = 8'($urandom);
      exp_q.push_back(b);
      u_tgt.rd_q.push_back(b);
    end
    apb_write(RegFdata, fmt_word(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, {TgtAddr, 1'b1}));
    apb_write(RegFdata, fmt_word(1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 8'(n)));
    wait_cmplt(st);
    exp_wm = 1'b0;
    if (code <= 3'd4) exp_wm = (n >= RxThr[code]);
    check_val("rx watermark", st[IntrRxWm], exp_wm);
    check_val("read nak", st[IntrNak], 0);
    apb_read(RegFifoStatus, st);
    check_val("rxlvl after read", st[21:16], n);
    for (int i = 0; i < n; i++) begin
      apb_read(RegRdata, st);
      check_val("rdata", st[7:0], exp_q[i]);
    end
    apb_read(RegFifoStatus, st);
    check_val("rxlvl after drain", st[21:16], 0);
  endtask

  task automatic nak_txn(input logic nakok);
    apb_data_t st;
    apb_write(RegIntrState, 32'h3f);
    apb_write(RegFdata, fmt_word(1'b1, 1'b1, 1'b0, 1'b0, nakok, {7'h21, 1'b0}));
    wait_cmplt(st);
    check_val("nak interrupt", st[IntrNak], !nakok);
  endtask

  task automatic fifo_test();
    apb_data_t st;
    apb_write(RegCtrl, 32'h0);
    apb_write(RegIntrState, 32'h3f);
    for (int i = 0; i < 33; i++) apb_write(RegFdata, fmt_word(0, 0, 0, 0, 0, 8'(i)));
    apb_read(RegFifoStatus, st);
    check_val("fmtlvl full", st[5:0], 32);
    apb_read(RegStatus, st);
    check_val("fmtfull", st[0], 1);
    apb_read(RegIntrState, st);
    check_val("fmt overflow", st[IntrFmtOvf], 1);
    apb_write(RegIntrState, 32'h3f);
    apb_write(RegFifoCtrl, 32'h2);
    apb_read(RegFifoStatus, st);
    check_val("fmtlvl after reset", st[5:0], 0);
    apb_read(RegIntrState, st);
    check_val("fmt watermark", st[IntrFmtWm], 1);
    apb_write(RegCtrl, 32'h1);
  endtask

  task automatic intr_test();
    intr_vec_t en;
    intr_vec_t v;
    apb_data_t st;
    en = 6'($urandom);
    v  = 6'($urandom);
    apb_write(RegIntrState, 32'h3f);
    apb_write(RegIntrEnable, {26'b0, en});
    apb_write(RegIntrTest, {26'b0, v});
    apb_read(RegIntrState, st);
    check_val("state after test", st[5:0], v);
    check_val("intr_o", intr, v & en);
    apb_write(RegIntrState, {26'b0, v});
    apb_read(RegIntrState, st);
    check_val("state after clear", st[5:0], 0);
    check_val("intr_o after clear", intr, 0);
  endtask

  // Unmapped and misaligned offsets must raise pslverr
  task automatic unmapped_test();
    apb_data_t st;
    apb_read(8'h2C, st);
    apb_read(8'h40, st);
    apb_read(8'h1A, st);
  endtask

  task automatic ovrd_test();
    logic sclv;
    logic sdav;
    for (int i = 0; i < 4; i++) begin
      sclv = i[0];
      sdav = i[1];
      apb_write(RegOvrd, {29'b0, sdav, sclv, 1'b1});
      check_val("scl override", dut_scl, sclv);
      check_val("sda override", dut_sda, sdav);
    end
    apb_write(RegOvrd, 32'h0);
  endtask

  initial begin
    rst_n   = 1'b0;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    errors  = 0;
    checks  = 0;
    void'($urandom(53));
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
    apb_write(RegTiming0, (Tlow << 16) | Thigh);
    apb_write(RegCtrl, 32'h1);
    for (int i = 0; i < NumWr; i++) write_txn($urandom_range(1, 4));
    for (int i = 0; i < NumRd; i++) read_txn($urandom_range(1, 4));
    nak_txn(1'b0);
    nak_txn(1'b1);
    fifo_test();
    intr_test();
    unmapped_test();
    ovrd_test();
    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
design/i2c_pkg.sv
design/i2c_fifo.sv
design/i2c_intr.sv
design/i2c_regs.sv
design/i2c_host_fsm.sv
design/i2c_core.sv
testbench/i2c_target_model.sv
testbench/tb_i2c_core.sv
